//--- Makefile
LOG = sim.log

all: run

obj_dir/VexeTb: flist.f $(wildcard *.sv)
	verilator --binary --timing --assert -f flist.f --top-module exeTb -o VexeTb

run: obj_dir/VexeTb
	./obj_dir/VexeTb | tee $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f flist.f --top-module exeTb

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

//--- csrUnit.sv
`timescale 1ns/1ps

module csrUnit import exePkg::*;
(
	input  csrOp_t          fn,
	input  logic [XLEN-1:0] rs1,
	input  logic [XLEN-1:0] imm,     // zimm, already zero extended
	input  logic [XLEN-1:0] old,
	input  logic [11:0]     addr,
	input  mode_t           mode,
	input  logic            weIn,
	output logic [XLEN-1:0] newVal,
	output logic            we,
	output logic            illegal
);

	logic [XLEN-1:0] src;

	// funct3 bit 2 picks the immediate forms
	assign src = fn[2] ? imm : rs1;

	always_comb
	begin
		case (fn)
			RW, RWI: newVal = src;
			RS, RSI: newVal = old | src;
			RC, RCI: newVal = old & ~src;
			default: newVal = old;
		endcase
	end

	// addr[9:8] is the lowest privilege allowed to touch this csr
	assign illegal = weIn && (addr[9:8] > mode);
	assign we      = weIn && !illegal;

endmodule

//--- exeAlu.sv
`timescale 1ns/1ps

module exeAlu import exePkg::*;
(
	input  aluOp_t          aluFn,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  logic            btype,
	input  logic            bNeq,
	output logic [XLEN-1:0] result,
	output logic            brTaken
);

	logic [4:0] shamt;
	logic       cond;

	assign shamt = b[4:0];

	always_comb
	begin
		case (aluFn)
			ADD:     result = a + b;
			SUB:     result = a - b;
			SLL:     result = a << shamt;
			SLT:     result = {31'b0, $signed(a) < $signed(b)};
			SLTU:    result = {31'b0, a < b};
			XOR:     result = a ^ b;
			SRL:     result = a >> shamt;
			SRA:     result = $signed(a) >>> shamt;
			OR:      result = a | b;
			AND:     result = a & b;
			default: result = '0;
		endcase
	end

	// beq/bne look at zero, the set-less-than forms at bit 0
	assign cond = (aluFn == SUB) ? (result == '0) : result[0];

	assign brTaken = btype && (cond != bNeq);

endmodule

//--- exePkg.sv
package exePkg;

	localparam int XLEN = 32;

	// alu function select
	typedef enum logic [3:0]
	{
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND
	} aluOp_t;

	typedef enum logic [2:0]
	{
		ALU,    // alu result
		LINK,   // pc + 4
		MULDIV,
		LUI,    // upper immediate as is
		AUIPC,  // pc + upper immediate
		CSR     // old csr value to rd
	} wbSel_t;

	typedef enum logic [2:0]
	{
		MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
	} mulDivOp_t;

	// same values as funct3 of the system opcode
	typedef enum logic [2:0]
	{
		RW  = 3'd1,
		RS  = 3'd2,
		RC  = 3'd3,
		RWI = 3'd5,
		RSI = 3'd6,
		RCI = 3'd7
	} csrOp_t;

	typedef enum logic [1:0]
	{
		USER    = 2'd0,
		SUPER   = 2'd1,
		MACHINE = 2'd3
	} mode_t;

	// mcause codes without the interrupt bit
	localparam logic [XLEN-2:0] CAUSE_ILLEGAL = 31'd2;
	localparam logic [XLEN-2:0] CAUSE_S_TIMER = 31'd5;
	localparam logic [XLEN-2:0] CAUSE_M_TIMER = 31'd7;
	localparam logic [XLEN-2:0] CAUSE_UCALL   = 31'd8;  // plus current mode
	localparam logic [XLEN-2:0] CAUSE_S_EXT   = 31'd9;
	localparam logic [XLEN-2:0] CAUSE_M_EXT   = 31'd11;

endpackage

//--- exeStage.sv
`timescale 1ns/1ps

module exeStage import exePkg::*;
(
	input  logic            clk,
	input  logic            nrst,
	input  logic [XLEN-1:0] opA,
	input  logic [XLEN-1:0] opB,
	input  logic [XLEN-1:0] bImm,
	input  logic [XLEN-1:0] jImm,
	input  logic [XLEN-1:0] uImm,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] csrImm,
	input  logic [XLEN-1:0] csrData,
	input  logic [4:0]      rd,
	input  wbSel_t          wbSel,
	input  aluOp_t          aluFn,
	input  mulDivOp_t       mulDivFn,
	input  csrOp_t          csrFn,
	input  logic [11:0]     csrAddr,
	input  logic            we,
	input  logic            btype,
	input  logic            bNeq,
	input  logic            j,
	input  logic            jr,
	input  logic            csrWeIn,
	input  logic            ecall,
	input  logic            illegal,
	input  logic            mret,
	input  logic            sret,
	input  mode_t           mode,
	input  logic            mTimer,
	input  logic            sTimer,
	input  logic            extIrq,
	input  logic            mTie,
	input  logic            sTie,
	input  logic            mEie,
	input  logic            sEie,
	output logic [XLEN-1:0] wbData,
	output logic [XLEN-1:0] pcWb,
	output logic [XLEN-1:0] target,
	output logic [XLEN-1:0] csrWbData,
	output logic [XLEN-1:0] cause,
	output logic [4:0]      rdWb,
	output logic [11:0]     csrWbAddr,
	output logic            weWb,
	output logic            csrWe,
	output logic            bjTaken,
	output logic            exception,
	output logic            mret6,
	output logic            sret6
);

	// stage 5 payload
	logic [XLEN-1:0] opA5, opB5, bImm5, jImm5, uImm5, pc5, csrImm5, csrData5;
	logic [4:0]      rd5;
	wbSel_t          wbSel5;
	aluOp_t          aluFn5;
	mulDivOp_t       mulDivFn5;
	csrOp_t          csrFn5;
	logic [11:0]     csrAddr5;
	logic            bNeq5;
	// stage 5 control, cleared on flush
	logic we5, btype5, j5, jr5, csrWe5, ecall5, illegal5, mret5, sret5;

	logic [XLEN-1:0] aluRes5, mulDivRes5, csrNew5, jrSum5;
	logic            brTaken5, csrWeOk5, csrIllegal5;

	// stage 6
	wbSel_t          wbSel6;
	logic [XLEN-1:0] aluRes6, mulDivRes6, uImm6, auipc6, csrOld6;
	logic            ecall6, illegal6;

	logic flush;

	assign flush = exception;  // a trap kills everything younger than commit

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			{we5, btype5, j5, jr5, csrWe5, ecall5, illegal5, mret5, sret5} <= '0;
		else if (flush)
			{we5, btype5, j5, jr5, csrWe5, ecall5, illegal5, mret5, sret5} <= '0;
		else
		begin
			we5      <= we;
			btype5   <= btype;
			j5       <= j;
			jr5      <= jr;
			csrWe5   <= csrWeIn;
			ecall5   <= ecall;
			illegal5 <= illegal;
			mret5    <= mret;
			sret5    <= sret;
		end
	end

	always_ff @(posedge clk)
	begin
		opA5      <= opA;
		opB5      <= opB;
		bImm5     <= bImm;
		jImm5     <= jImm;
		uImm5     <= uImm;
		pc5       <= pc;
		csrImm5   <= csrImm;
		csrData5  <= csrData;
		rd5       <= rd;
		wbSel5    <= wbSel;
		aluFn5    <= aluFn;
		mulDivFn5 <= mulDivFn;
		csrFn5    <= csrFn;
		csrAddr5  <= csrAddr;
		bNeq5     <= bNeq;
	end

	exeAlu i_alu (
		.aluFn   (aluFn5),
		.a       (opA5),
		.b       (opB5),
		.btype   (btype5),
		.bNeq    (bNeq5),
		.result  (aluRes5),
		.brTaken (brTaken5)
	);

	mulDiv i_mulDiv (
		.a   (opA5),
		.b   (opB5),
		.op  (mulDivFn5),
		.res (mulDivRes5)
	);

	csrUnit i_csr (
		.fn      (csrFn5),
		.rs1     (opA5),
		.imm     (csrImm5),
		.old     (csrData5),
		.addr    (csrAddr5),
		.mode    (mode),
		.weIn    (csrWe5),
		.newVal  (csrNew5),
		.we      (csrWeOk5),
		.illegal (csrIllegal5)
	);

	// branch and jump resolution straight out of stage 5
	assign jrSum5  = opA5 + opB5;
	assign bjTaken = brTaken5 || j5 || jr5;

	always_comb
	begin
		if (j5)
			target = pc5 + jImm5;
		else if (jr5)
			target = {jrSum5[XLEN-1:1], 1'b0};
		else
			target = pc5 + bImm5;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			{weWb, csrWe, ecall6, illegal6, mret6, sret6} <= '0;
		else if (flush)
			{weWb, csrWe, ecall6, illegal6, mret6, sret6} <= '0;
		else
		begin
			weWb     <= we5;
			csrWe    <= csrWeOk5;
			ecall6   <= ecall5;
			illegal6 <= illegal5 || csrIllegal5;  // decode or privilege
			mret6    <= mret5;
			sret6    <= sret5;
		end
	end

	// pcWb keeps following stage 5 during a flush
	always_ff @(posedge clk)
	begin
		wbSel6     <= wbSel5;
		aluRes6    <= aluRes5;
		mulDivRes6 <= mulDivRes5;
		uImm6      <= uImm5;
		auipc6     <= pc5 + uImm5;
		csrOld6    <= csrData5;
		pcWb       <= pc5;
		rdWb       <= rd5;
		csrWbData  <= csrNew5;
		csrWbAddr  <= csrAddr5;
	end

	trapUnit i_trap (
		.ecall     (ecall6),
		.illegal   (illegal6),
		.mret      (mret6),
		.sret      (sret6),
		.mode      (mode),
		.mTimer    (mTimer),
		.sTimer    (sTimer),
		.extIrq    (extIrq),
		.mTie      (mTie),
		.sTie      (sTie),
		.mEie      (mEie),
		.sEie      (sEie),
		.exception (exception),
		.cause     (cause)
	);

	always_comb
	begin
		case (wbSel6)
			ALU:     wbData = aluRes6;
			LINK:    wbData = pcWb + 32'd4;
			MULDIV:  wbData = mulDivRes6;
			LUI:     wbData = uImm6;
			AUIPC:   wbData = auipc6;
			CSR:     wbData = csrOld6;
			default: wbData = '0;
		endcase
	end

endmodule

//--- exeStage_properties.sv
`timescale 1ns/1ps

module exeStage_properties import exePkg::*;
(
	input logic            clk,
	input logic            nrst,
	input logic            weWb,
	input logic            csrWe,
	input logic            exception,
	input logic [XLEN-1:0] cause,
	input logic [XLEN-1:0] target,
	input logic            j5,
	input logic            jr5
);

	// a trap empties stage 6
	noWbAfterTrap: assert property (@(posedge clk) disable iff (!nrst)
		exception |=> !weWb)
		else $error("weWb high in the cycle after an exception");

	irqIsTrap: assert property (@(posedge clk) disable iff (!nrst)
		cause[XLEN-1] |-> exception)
		else $error("interrupt cause without exception");

	jrAligned: assert property (@(posedge clk) disable iff (!nrst)
		(jr5 && !j5) |-> !target[0])
		else $error("jr target has bit 0 set");

	csrQuietAfterReset: assert property (@(posedge clk) !nrst |=> !csrWe)
		else $error("csrWe high right after reset");

endmodule

bind exeStage exeStage_properties i_props
(
	.clk       (clk),
	.nrst      (nrst),
	.weWb      (weWb),
	.csrWe     (csrWe),
	.exception (exception),
	.cause     (cause),
	.target    (target),
	.j5        (j5),
	.jr5       (jr5)
);

//--- exeTb.sv
`timescale 1ns/1ps

module exeTb import exePkg::*; ();

	localparam int RESET_CYCLES = 8;
	localparam int NUM_INSTR    = 2000;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_INSTR + 92;  // drain plus margin

	logic            clk = 1'b0;
	logic            nrst;
	logic [XLEN-1:0] opA, opB, bImm, jImm, uImm, pc, csrImm, csrData;
	logic [4:0]      rd;
	wbSel_t          wbSel;
	aluOp_t          aluFn;
	mulDivOp_t       mulDivFn;
	csrOp_t          csrFn;
	logic [11:0]     csrAddr;
	logic            we, btype, bNeq, j, jr, csrWeIn, ecall, illegal, mret, sret;
	mode_t           mode;
	logic            mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie;

	logic [XLEN-1:0] wbData, pcWb, target, csrWbData, cause;
	logic [4:0]      rdWb;
	logic [11:0]     csrWbAddr;
	logic            weWb, csrWe, bjTaken, exception, mret6, sret6;

	// model of what stage 5 and stage 6 should hold
	logic            x5Taken;
	logic [XLEN-1:0] x5Target, x5Wb, x5Pc, x5CsrNew;
	logic [4:0]      x5Rd;
	logic [11:0]     x5CsrAddr;
	logic            x5We, x5CsrWe, x5Ecall, x5Ill, x5Mret, x5Sret;
	logic [XLEN-1:0] x6Wb, x6Pc, x6CsrNew;
	logic [4:0]      x6Rd;
	logic [11:0]     x6CsrAddr;
	logic            x6We, x6CsrWe, x6Ecall, x6Ill, x6Mret, x6Sret;

	integer seed   = 90855;
	int     cycles = 0;

	exeStage i_dut (.*);

	always #20 clk = ~clk;

	function automatic int unsigned pick(int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [XLEN-1:0] aluModel(aluOp_t fn, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
		case (fn)
			ADD:     return a + b;
			SUB:     return a - b;
			SLL:     return a << b[4:0];
			SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			SLTU:    return (a < b) ? 32'd1 : 32'd0;
			XOR:     return a ^ b;
			SRL:     return a >> b[4:0];
			SRA:     return $unsigned($signed(a) >>> b[4:0]);
			OR:      return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] mulDivModel(mulDivOp_t fn, logic [XLEN-1:0] a,
		logic [XLEN-1:0] b);
		logic [63:0] sa;
		logic [63:0] sb;
		logic [63:0] zb;
		logic [63:0] p;
		logic        ovf;
		sa  = {{32{a[31]}}, a};
		sb  = {{32{b[31]}}, b};
		zb  = {32'b0, b};
		ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (fn)
			MUL:    return a * b;
			MULH:   p = sa * sb;  // low 64 bits of the signed product
			MULHSU: p = sa * zb;
			MULHU:  p = {32'b0, a} * zb;
			DIV:    return (b == 0) ? 32'hffff_ffff : ovf ? a : $unsigned($signed(a) / $signed(b));
			DIVU:   return (b == 0) ? 32'hffff_ffff : a / b;
			REM:    return (b == 0) ? a : ovf ? 32'd0 : $unsigned($signed(a) % $signed(b));
			default: return (b == 0) ? a : a % b;
		endcase
		return p[63:32];
	endfunction

	function automatic logic [XLEN-1:0] csrModel(csrOp_t fn, logic [XLEN-1:0] rs1,
		logic [XLEN-1:0] zimm, logic [XLEN-1:0] old);
		logic [XLEN-1:0] src;
		src = (fn inside {RWI, RSI, RCI}) ? zimm : rs1;
		case (fn)
			RW, RWI: return src;
			RS, RSI: return old | src;
			default: return old & ~src;
		endcase
	endfunction

	// returns {exception, cause} for the live interrupt lines
	function automatic logic [XLEN:0] trapModel(logic ec, logic il, logic mr, logic sr, mode_t m);
		logic sAllowed;
		sAllowed = (m != MACHINE);
		if (extIrq && mEie)
			return {2'b11, CAUSE_M_EXT};
		if (extIrq && sEie && sAllowed)
			return {2'b11, CAUSE_S_EXT};
		if (mTimer && mTie)
			return {2'b11, CAUSE_M_TIMER};
		if (sTimer && sTie && sAllowed)
			return {2'b11, CAUSE_S_TIMER};
		if (ec)
			return {2'b10, CAUSE_UCALL + 31'(m)};
		if (il)
			return {2'b10, CAUSE_ILLEGAL};
		return {mr || sr, 32'd0};
	endfunction

	task automatic expectEq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
		input string what);
		assert (got === exp)
		else
		begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic idleInputs();
		{opA, opB, bImm, jImm, uImm, pc, csrImm, csrData} <= '0;
		{rd, csrAddr, bNeq, mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie} <= '0;
		{we, btype, j, jr, csrWeIn, ecall, illegal, mret, sret} <= '0;
		wbSel    <= ALU;
		aluFn    <= ADD;
		mulDivFn <= MUL;
		csrFn    <= RW;
		mode     <= USER;
	endtask

	task automatic issueRandom();
		int unsigned kind;
		int unsigned m;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		kind = pick(16);
		m    = pick(3);
		a    = $random(seed);
		b    = (pick(4) == 0) ? a : $random(seed);  // equal operands now and then
		if (kind inside {3, 4} && pick(3) == 0)
		begin
			a = 32'h8000_0000;  // divide corner cases
			b = pick(2) ? 32'hffff_ffff : 32'd0;
		end
		idleInputs();
		opA      <= a;
		opB      <= b;
		bImm     <= $random(seed) & ~32'd1;
		jImm     <= $random(seed) & ~32'd1;
		uImm     <= $random(seed) & 32'hffff_f000;
		pc       <= $random(seed) & 32'hffff_fffc;
		csrImm   <= 32'(pick(32));
		csrData  <= $random(seed);
		rd       <= 5'(pick(32));
		csrAddr  <= 12'(pick(4096));
		bNeq     <= pick(2) == 1;
		aluFn    <= aluOp_t'(pick(10));
		mulDivFn <= mulDivOp_t'(pick(8));
		csrFn    <= csrOp_t'(pick(2) * 4 + 1 + pick(3));
		mode     <= mode_t'((m == 2) ? 3 : m);
		mTimer   <= pick(24) == 0;
		sTimer   <= pick(24) == 0;
		extIrq   <= pick(24) == 0;
		{mTie, sTie, mEie, sEie} <= 4'(pick(16));
		case (kind)
			0, 1, 2: we <= 1'b1;
			3, 4:
			begin
				we    <= 1'b1;
				wbSel <= MULDIV;
			end
			5, 6:
			begin
				btype <= 1'b1;
				aluFn <= (m == 0) ? SUB : (m == 1) ? SLT : SLTU;
			end
			7, 8:
			begin
				we    <= 1'b1;
				wbSel <= LINK;
				j     <= (kind == 7);
				jr    <= (kind == 8);
			end
			9, 10:
			begin
				we    <= 1'b1;
				wbSel <= (kind == 9) ? LUI : AUIPC;
			end
			11, 12:
			begin
				we      <= 1'b1;
				wbSel   <= CSR;
				csrWeIn <= 1'b1;
			end
			13:
			begin
				m = pick(4);  // system instructions never write rd
				ecall   <= (m == 0);
				illegal <= (m == 1);
				mret    <= (m == 2);
				sret    <= (m == 3);
			end
			default: ;  // bubble
		endcase
	endtask

	// model advances on the same edge as the DUT, from the inputs it captures
	always @(posedge clk)
	begin
		logic [XLEN:0]   trap;
		logic [XLEN-1:0] aluRes;
		logic            flush;
		logic            csrBad;
		logic            cmp;
		trap   = trapModel(x6Ecall, x6Ill, x6Mret, x6Sret, mode);
		flush  = trap[XLEN] || !nrst;
		csrBad = x5CsrWe && (x5CsrAddr[9:8] > mode);

		x6Wb      = x5Wb;
		x6Pc      = x5Pc;
		x6Rd      = x5Rd;
		x6CsrNew  = x5CsrNew;
		x6CsrAddr = x5CsrAddr;
		x6We      = x5We && !flush;
		x6CsrWe   = x5CsrWe && !csrBad && !flush;
		x6Ecall   = x5Ecall && !flush;
		x6Ill     = (x5Ill || csrBad) && !flush;
		x6Mret    = x5Mret && !flush;
		x6Sret    = x5Sret && !flush;

		aluRes    = aluModel(aluFn, opA, opB);
		x5Pc      = pc;
		x5Rd      = rd;
		x5CsrAddr = csrAddr;
		x5CsrNew  = csrModel(csrFn, opA, csrImm, csrData);
		x5We      = we && !flush;
		x5CsrWe   = csrWeIn && !flush;
		x5Ecall   = ecall && !flush;
		x5Ill     = illegal && !flush;
		x5Mret    = mret && !flush;
		x5Sret    = sret && !flush;
		// beq/bne test equality, blt/bltu and friends test less-than
		case (aluFn)
			SUB:     cmp = (opA == opB);
			SLT:     cmp = $signed(opA) < $signed(opB);
			default: cmp = opA < opB;
		endcase
		x5Taken = !flush && (j || jr || (btype && (cmp != bNeq)));
		if (j && !flush)
			x5Target = pc + jImm;
		else if (jr && !flush)
			x5Target = (opA + opB) & ~32'd1;
		else
			x5Target = pc + bImm;
		case (wbSel)
			ALU:     x5Wb = aluRes;
			LINK:    x5Wb = pc + 32'd4;
			MULDIV:  x5Wb = mulDivModel(mulDivFn, opA, opB);
			LUI:     x5Wb = uImm;
			AUIPC:   x5Wb = pc + uImm;
			default: x5Wb = csrData;
		endcase
	end

	// outputs are settled half a period after the edge
	always @(negedge clk)
	begin
		logic [XLEN:0] trap;
		trap = trapModel(x6Ecall, x6Ill, x6Mret, x6Sret, mode);
		if (nrst)
		begin
			expectEq(exception, trap[XLEN], "exception");
			expectEq(cause, trap[XLEN-1:0], "cause");
			expectEq(bjTaken, x5Taken, "bjTaken");
			expectEq(target, x5Target, "target");
			expectEq(weWb, x6We, "weWb");
			expectEq(pcWb, x6Pc, "pcWb");
			expectEq(csrWe, x6CsrWe, "csrWe");
			expectEq(mret6, x6Mret, "mret6");
			expectEq(sret6, x6Sret, "sret6");
			if (x6We)
			begin
				expectEq(wbData, x6Wb, "wbData");
				expectEq(rdWb, x6Rd, "rdWb");
			end
			if (x6CsrWe)
			begin
				expectEq(csrWbData, x6CsrNew, "csrWbData");
				expectEq(csrWbAddr, x6CsrAddr, "csrWbAddr");
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		nrst <= 1'b0;
		idleInputs();
		repeat (RESET_CYCLES) @(posedge clk);
		nrst <= 1'b1;
		for (int i = 0; i < NUM_INSTR; i++)
		begin
			issueRandom();
			@(posedge clk);
		end
		idleInputs();
		repeat (3) @(posedge clk);  // let the last two instructions drain
		@(negedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule

//--- flist.f
exePkg.sv
exeAlu.sv
mulDiv.sv
csrUnit.sv
trapUnit.sv
exeStage.sv
exeStage_properties.sv
exeTb.sv

//--- mulDiv.sv
`timescale 1ns/1ps

module mulDiv import exePkg::*;
(
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  mulDivOp_t       op,
	output logic [XLEN-1:0] res
);

	logic            aSigned, bSigned;
	logic [XLEN:0]   aExt, bExt;     // one extra bit so every mode fits a signed multiply
	logic [2*XLEN+1:0] prod;
	logic            divZero;
	logic            overflow;       // most negative / -1

	assign aSigned = (op == MULH) || (op == MULHSU);
	assign bSigned = (op == MULH);

	assign aExt = {aSigned & a[XLEN-1], a};
	assign bExt = {bSigned & b[XLEN-1], b};
	assign prod = $signed(aExt) * $signed(bExt);

	assign divZero  = (b == '0);
	assign overflow = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);

	always_comb
	begin
		case (op)
			MUL:    res = prod[XLEN-1:0];
			MULH,
			MULHSU,
			MULHU:  res = prod[2*XLEN-1:XLEN];
			DIV:
				if (divZero)       res = '1;
				else if (overflow) res = a;
				else               res = $signed(a) / $signed(b);
			DIVU:   res = divZero ? '1 : a / b;
			REM:
				if (divZero)       res = a;
				else if (overflow) res = '0;
				else               res = $signed(a) % $signed(b);
			REMU:   res = divZero ? a : a % b;
			default: res = '0;
		endcase
	end

endmodule

//--- trapUnit.sv
`timescale 1ns/1ps

module trapUnit import exePkg::*;
(
	input  logic            ecall,
	input  logic            illegal,
	input  logic            mret,
	input  logic            sret,
	input  mode_t           mode,
	input  logic            mTimer,
	input  logic            sTimer,
	input  logic            extIrq,
	input  logic            mTie,
	input  logic            sTie,
	input  logic            mEie,
	input  logic            sEie,
	output logic            exception,
	output logic [XLEN-1:0] cause
);

	logic sOk;  // supervisor interrupts only below machine mode
	logic mTimerQ, sTimerQ, mExtQ, sExtQ;

	assign sOk     = (mode <= SUPER);
	assign mTimerQ = mTie && mTimer;
	assign sTimerQ = sOk && sTie && sTimer;
	assign mExtQ   = mEie && extIrq;
	assign sExtQ   = sOk && sEie && extIrq;

	assign exception = mExtQ || sExtQ || mTimerQ || sTimerQ
		|| ecall || illegal || mret || sret;

	always_comb
	begin
		if (mExtQ)
			cause = {1'b1, CAUSE_M_EXT};
		else if (sExtQ)
			cause = {1'b1, CAUSE_S_EXT};
		else if (mTimerQ)
			cause = {1'b1, CAUSE_M_TIMER};
		else if (sTimerQ)
			cause = {1'b1, CAUSE_S_TIMER};
		else if (ecall)
			cause = {1'b0, CAUSE_UCALL + {29'b0, mode}};  // ucall, scall, mcall
		else if (illegal)
			cause = {1'b0, CAUSE_ILLEGAL};
		else
			cause = '0;  // xret or nothing
	end

endmodule
